//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP   = tb_mgmt
FLIST = sources.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

# the run fails unless the log holds the pass line
run: compile
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -qxF '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- mgmt_consts.svh
`ifndef MGMT_CONSTS_SVH
`define MGMT_CONSTS_SVH

// management port widths
`define MGMT_DATA_W     32
`define MGMT_ADDR_W     10

// receive statistics
`define STAT_W          64              // one counter, read back as two words
`define NUM_RX_STAT     19
`define STAT_IDX_W      5

// address bit 9 high selects config space, low selects statistics
`define CFG_SPACE_BIT   9

// config register offsets within addr[8:0]
`define CFG_ADDR_RX0    9'h000
`define CFG_ADDR_RX1    9'h040
`define CFG_ADDR_TX     9'h080
`define CFG_ADDR_FC     9'h0C0
`define CFG_ADDR_RS     9'h100

// config register reset values
`define CFG_RST_RX0     32'h0000_0000
`define CFG_RST_RX1     32'h1000_0000
`define CFG_RST_TX      32'h1000_0000
`define CFG_RST_FC      32'h6000_0000
`define CFG_RST_RS      32'h0000_0000

// packed vectors to the receive and transmit paths
`define CFG_RX_W        53
`define CFG_TX_W        10

`endif

//--- mgmt_decode.sv
`timescale 1ns/10ps
`include "mgmt_consts.svh"

module mgmt_decode import mgmt_pkg::*; (
        input  logic                            rxclk,
        input  logic                            reset,
        input  logic                            mgmt_req_i,     // single cycle strobe
        input  mgmt_op_e                        mgmt_opcode_i,
        input  logic [`MGMT_ADDR_W-1:0]         mgmt_addr_i,
        input  logic [`MGMT_DATA_W-1:0]         mgmt_wr_data_i,
        output logic                            mgmt_rdy_o,
        mgmt_req_if.dec                         req
);

        logic           accept;         // request seen while ready
        logic           cfg_space;
        logic           is_rd;
        logic           is_wr;
        logic           take;           // accepted and worth executing
        logic [1:0]     busy_cnt;       // cycles left in a stat read
        cfg_sel_e       sel_d;

        ////////////////////
        // classify

        assign accept    = mgmt_req_i & mgmt_rdy_o;
        assign cfg_space = mgmt_addr_i[`CFG_SPACE_BIT];
        assign is_rd     = (mgmt_opcode_i == OP_READ);
        assign is_wr     = (mgmt_opcode_i == OP_WRITE);
        // statistics space is read only, writes there are dropped here
        assign take      = accept & (cfg_space ? (is_rd | is_wr) : is_rd);

        always_comb begin
                case (mgmt_addr_i[`CFG_SPACE_BIT-1:0])
                        `CFG_ADDR_RX0: sel_d = CFG_RX0;
                        `CFG_ADDR_RX1: sel_d = CFG_RX1;
                        `CFG_ADDR_TX:  sel_d = CFG_TX;
                        `CFG_ADDR_FC:  sel_d = CFG_FC;
                        `CFG_ADDR_RS:  sel_d = CFG_RS;
                        default:       sel_d = CFG_NONE;        // reads back zero
                endcase
        end

        ////////////////////
        // request register

        always_ff @(posedge rxclk or posedge reset) begin
                if (reset)
                        req.valid <= 1'b0;
                else
                        req.valid <= take;
        end

        always_ff @(posedge rxclk) begin
                if (take) begin
                        req.kind    <= cfg_space ? (is_wr ? KIND_CFG_WR : KIND_CFG_RD)
                                                 : KIND_STAT_RD;
                        req.cfg_sel <= sel_d;
                        // offsets past 0x1f park on an index that reads zero
                        req.stat_idx <= (|mgmt_addr_i[`CFG_SPACE_BIT-1:`STAT_IDX_W]) ?
                                        '1 : mgmt_addr_i[`STAT_IDX_W-1:0];
                        req.wr_data <= mgmt_wr_data_i;
                end
        end

        ////////////////////
        // ready tracking

        always_ff @(posedge rxclk or posedge reset) begin
                if (reset)
                        busy_cnt <= 2'd0;
                else if (accept && !cfg_space && is_rd)
                        busy_cnt <= 2'd3;               // execute, low word, high word
                else if (busy_cnt != 2'd0)
                        busy_cnt <= busy_cnt - 2'd1;
        end

        assign mgmt_rdy_o = (busy_cnt == 2'd0);     // cfg requests never stall

endmodule

//--- mgmt_execute.sv
`timescale 1ns/10ps
`include "mgmt_consts.svh"

module mgmt_execute import mgmt_pkg::*; (
        input  logic                            rxclk,
        input  logic                            reset,
        mgmt_req_if.exe                         req,
        input  logic [`NUM_RX_STAT-1:0]         rx_stat_inc_i,  // one strobe per counter
        output logic [`CFG_RX_W-1:0]            cfg_rx_o,
        output logic [`CFG_TX_W-1:0]            cfg_tx_o,
        output logic                            rd_valid_o,
        output logic                            rd_wide_o,      // stat read, two words
        output logic [`STAT_W-1:0]              rd_data_o
);

        logic [`MGMT_DATA_W-1:0]        rx_cfg0;        // receive config 0
        logic [`MGMT_DATA_W-1:0]        rx_cfg1;        // receive config 1
        logic [`MGMT_DATA_W-1:0]        tx_cfg;
        logic [`MGMT_DATA_W-1:0]        fc_cfg;         // flow control
        logic [`MGMT_DATA_W-1:0]        rs_cfg;         // reconciliation sublayer
        logic [`STAT_W-1:0]             stat_cnt [`NUM_RX_STAT];
        logic [`MGMT_DATA_W-1:0]        cfg_word;
        logic [`STAT_W-1:0]             stat_word;
        logic                           cfg_wr;
        logic                           rd_req;

        assign cfg_wr = req.valid & (req.kind == KIND_CFG_WR);
        assign rd_req = req.valid & (req.kind != KIND_CFG_WR);

        ////////////////////
        // config registers

        always_ff @(posedge rxclk or posedge reset) begin
                if (reset) begin
                        rx_cfg0 <= `CFG_RST_RX0;
                        rx_cfg1 <= `CFG_RST_RX1;
                        tx_cfg  <= `CFG_RST_TX;
                        fc_cfg  <= `CFG_RST_FC;
                        rs_cfg  <= `CFG_RST_RS;
                end else if (cfg_wr) begin
                        case (req.cfg_sel)
                                CFG_RX0: rx_cfg0 <= req.wr_data;
                                CFG_RX1: rx_cfg1 <= req.wr_data;
                                CFG_TX:  tx_cfg  <= req.wr_data;
                                CFG_FC:  fc_cfg  <= req.wr_data;
                                CFG_RS:  rs_cfg  <= req.wr_data;
                                default: ;                      // unmapped, dropped
                        endcase
                end
        end

        // vectors follow the registers directly, a write shows from E1
        assign cfg_rx_o = {rx_cfg1[31:27], rx_cfg1[15:0], rx_cfg0};
        assign cfg_tx_o = {rs_cfg[27], tx_cfg[31:24], fc_cfg[30]};

        ////////////////////
        // rx statistics

        always_ff @(posedge rxclk or posedge reset) begin
                if (reset) begin
                        for (int i = 0; i < `NUM_RX_STAT; i++)
                                stat_cnt[i] <= '0;
                end else begin
                        for (int i = 0; i < `NUM_RX_STAT; i++)
                                if (rx_stat_inc_i[i])
                                        stat_cnt[i] <= stat_cnt[i] + 1'b1;
                end
        end

        ////////////////////
        // read data

        always_comb begin
                case (req.cfg_sel)
                        CFG_RX0: cfg_word = rx_cfg0;
                        CFG_RX1: cfg_word = rx_cfg1;
                        CFG_TX:  cfg_word = tx_cfg;
                        CFG_FC:  cfg_word = fc_cfg;
                        CFG_RS:  cfg_word = rs_cfg;
                        default: cfg_word = '0;
                endcase
        end

        // index 0x13 and up has no counter behind it
        assign stat_word = (req.stat_idx < `STAT_IDX_W'(`NUM_RX_STAT)) ?
                           stat_cnt[req.stat_idx] : '0;

        always_ff @(posedge rxclk or posedge reset) begin
                if (reset) begin
                        rd_valid_o <= 1'b0;
                        rd_wide_o  <= 1'b0;
                end else begin
                        rd_valid_o <= rd_req;
                        rd_wide_o  <= rd_req & (req.kind == KIND_STAT_RD);
                end
        end

        // counter value as it stood before this edge
        always_ff @(posedge rxclk) begin
                if (rd_req)
                        rd_data_o <= (req.kind == KIND_STAT_RD) ? stat_word
                                                                : {32'b0, cfg_word};
        end

endmodule

//--- mgmt_pkg.sv
package mgmt_pkg;

        // opcode on the management port, 00 and 11 are not decoded
        typedef enum logic [1:0] {
                OP_WRITE = 2'b01,
                OP_READ  = 2'b10
        } mgmt_op_e;

        // class of an accepted request
        typedef enum logic [1:0] {
                KIND_CFG_WR,
                KIND_CFG_RD,
                KIND_STAT_RD
        } req_kind_e;

        // target config register, CFG_NONE for an unmapped offset
        typedef enum logic [2:0] {
                CFG_RX0,
                CFG_RX1,
                CFG_TX,
                CFG_FC,
                CFG_RS,
                CFG_NONE
        } cfg_sel_e;

        // result stage, RES_HIGH sends the upper statistics word
        typedef enum logic {
                RES_IDLE,
                RES_HIGH
        } res_state_e;

endpackage

//--- mgmt_req_if.sv
`timescale 1ns/10ps
`include "mgmt_consts.svh"

// decoded request, one cycle strobe, no back-pressure
interface mgmt_req_if import mgmt_pkg::*; ();

        logic                           valid;          // request strobe
        req_kind_e                      kind;           // cfg write, cfg read or stat read
        cfg_sel_e                       cfg_sel;        // config register target
        logic [`STAT_IDX_W-1:0]         stat_idx;       // counter index
        logic [`MGMT_DATA_W-1:0]        wr_data;        // config write data

        // decode side
        modport dec (
                output valid,
                output kind,
                output cfg_sel,
                output stat_idx,
                output wr_data
        );

        // execute side
        modport exe (
                input valid,
                input kind,
                input cfg_sel,
                input stat_idx,
                input wr_data
        );

endinterface

//--- mgmt_result.sv
`timescale 1ns/10ps
`include "mgmt_consts.svh"

module mgmt_result import mgmt_pkg::*; (
        input  logic                            rxclk,
        input  logic                            reset,
        input  logic                            rd_valid_i,
        input  logic                            rd_wide_i,      // high word follows
        input  logic [`STAT_W-1:0]              rd_data_i,
        output logic [`MGMT_DATA_W-1:0]         mgmt_rd_data_o,
        output logic                            mgmt_rd_valid_o
);

        res_state_e                     state;
        logic [`MGMT_DATA_W-1:0]        hi_word;        // upper half of a stat read

        always_ff @(posedge rxclk) begin
                if (rd_valid_i && rd_wide_i)
                        hi_word <= rd_data_i[`STAT_W-1:`MGMT_DATA_W];
        end

        ////////////////////
        // word sequencing

        always_ff @(posedge rxclk or posedge reset) begin
                if (reset) begin
                        state           <= RES_IDLE;
                        mgmt_rd_valid_o <= 1'b0;
                        mgmt_rd_data_o  <= '0;
                end else begin
                        case (state)
                                RES_IDLE: begin
                                        mgmt_rd_valid_o <= rd_valid_i;
                                        if (rd_valid_i) begin
                                                // low word goes out first
                                                mgmt_rd_data_o <= rd_data_i[`MGMT_DATA_W-1:0];
                                                if (rd_wide_i)
                                                        state <= RES_HIGH;
                                        end
                                end
                                RES_HIGH: begin
                                        mgmt_rd_valid_o <= 1'b1;
                                        mgmt_rd_data_o  <= hi_word;
                                        state           <= RES_IDLE;
                                end
                                default: begin
                                        mgmt_rd_valid_o <= 1'b0;
                                        state           <= RES_IDLE;
                                end
                        endcase
                end
        end

        // data holds between reads, only valid moves back low

endmodule

//--- mgmt_top.sv
`timescale 1ns/10ps
`include "mgmt_consts.svh"

module mgmt_top import mgmt_pkg::*; (
        input  logic                            rxclk,
        input  logic                            reset,
        input  logic                            mgmt_req_i,
        input  mgmt_op_e                        mgmt_opcode_i,
        input  logic [`MGMT_ADDR_W-1:0]         mgmt_addr_i,
        input  logic [`MGMT_DATA_W-1:0]         mgmt_wr_data_i,
        input  logic [`NUM_RX_STAT-1:0]         rx_stat_inc_i,
        output logic [`MGMT_DATA_W-1:0]         mgmt_rd_data_o,
        output logic                            mgmt_rd_valid_o,
        output logic                            mgmt_rdy_o,
        output logic [`CFG_RX_W-1:0]            cfg_rx_o,
        output logic [`CFG_TX_W-1:0]            cfg_tx_o
);

        logic                   rd_valid;       // execute to result
        logic                   rd_wide;
        logic [`STAT_W-1:0]     rd_data;

        mgmt_req_if req_bus ();                 // decode to execute

        ////////////////////
        // stages

        mgmt_decode u_decode (
                .rxclk          (rxclk),
                .reset          (reset),
                .mgmt_req_i     (mgmt_req_i),
                .mgmt_opcode_i  (mgmt_opcode_i),
                .mgmt_addr_i    (mgmt_addr_i),
                .mgmt_wr_data_i (mgmt_wr_data_i),
                .mgmt_rdy_o     (mgmt_rdy_o),
                .req            (req_bus.dec)
        );

        mgmt_execute u_execute (
                .rxclk          (rxclk),
                .reset          (reset),
                .req            (req_bus.exe),
                .rx_stat_inc_i  (rx_stat_inc_i),
                .cfg_rx_o       (cfg_rx_o),
                .cfg_tx_o       (cfg_tx_o),
                .rd_valid_o     (rd_valid),
                .rd_wide_o      (rd_wide),
                .rd_data_o      (rd_data)
        );

        mgmt_result u_result (
                .rxclk           (rxclk),
                .reset           (reset),
                .rd_valid_i      (rd_valid),
                .rd_wide_i       (rd_wide),
                .rd_data_i       (rd_data),
                .mgmt_rd_data_o  (mgmt_rd_data_o),
                .mgmt_rd_valid_o (mgmt_rd_valid_o)
        );

endmodule

//--- sources.f
+incdir+.
mgmt_pkg.sv
mgmt_req_if.sv
mgmt_decode.sv
mgmt_execute.sv
mgmt_result.sv
mgmt_top.sv
tb_mgmt_assert.sv
tb_mgmt.sv

//--- tb_mgmt.sv
`timescale 1ns/10ps
`include "mgmt_consts.svh"

module tb_mgmt import mgmt_pkg::*; ();

        localparam int MAX_BURST = 16;          // longest increment burst
        localparam int RESET_CYC = 8;

        typedef struct {
                mgmt_op_e       op;
                logic [9:0]     addr;
                logic [31:0]    wdata;
                logic [63:0]    exp;            // fixed expected value
                int             midx;           // model counter or -1 for exp
                int             nw;             // words read back or 0 for a write
                bit             shadow;         // extra write in the busy window
        } entry_t;

        logic                           rxclk;
        logic                           reset;
        logic                           mgmt_req;
        mgmt_op_e                       mgmt_opcode;
        logic [`MGMT_ADDR_W-1:0]        mgmt_addr;
        logic [`MGMT_DATA_W-1:0]        mgmt_wr_data;
        logic [`NUM_RX_STAT-1:0]        rx_stat_inc;
        logic [`MGMT_DATA_W-1:0]        mgmt_rd_data;
        logic                           mgmt_rd_valid;
        logic                           mgmt_rdy;
        logic [`CFG_RX_W-1:0]           cfg_rx;
        logic [`CFG_TX_W-1:0]           cfg_tx;

        entry_t                         entries [$];
        logic [31:0]                    cfg_model [5];          // rx0 rx1 tx fc rs
        logic [63:0]                    model_cnt [`NUM_RX_STAT];
        logic [31:0]                    lfsr;
        int                             errors = 0;
        int                             tests = 0;
        int                             failed = 0;
        int                             cycles = 0;
        int                             cycle_limit = 0;

        mgmt_top mgmt_top_i (
                .rxclk           (rxclk),
                .reset           (reset),
                .mgmt_req_i      (mgmt_req),
                .mgmt_opcode_i   (mgmt_opcode),
                .mgmt_addr_i     (mgmt_addr),
                .mgmt_wr_data_i  (mgmt_wr_data),
                .rx_stat_inc_i   (rx_stat_inc),
                .mgmt_rd_data_o  (mgmt_rd_data),
                .mgmt_rd_valid_o (mgmt_rd_valid),
                .mgmt_rdy_o      (mgmt_rdy),
                .cfg_rx_o        (cfg_rx),
                .cfg_tx_o        (cfg_tx)
        );

        bind mgmt_top mgmt_assert u_assert (
                .rxclk (rxclk), .reset (reset), .req_i (mgmt_req_i),
                .opcode_i (mgmt_opcode_i), .addr_i (mgmt_addr_i),
                .rdy_i (mgmt_rdy_o), .rd_valid_i (mgmt_rd_valid_o)
        );

        initial begin
                rxclk = 1'b0;
                forever #4 rxclk = ~rxclk;      // 8 ns period
        end

        ////////////////////
        // helpers

        // x^32 + x^22 + x^2 + x + 1
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        task automatic rand_bits(input int n, output logic [31:0] v);
                v = '0;
                for (int i = 0; i < n; i++) begin
                        v    = {v[30:0], lfsr[31]};     // one step per bit
                        lfsr = lfsr_step(lfsr);
                end
        endtask

        function automatic int cfg_index(input logic [9:0] addr);
                case (addr[8:0])
                        `CFG_ADDR_RX0: return 0;
                        `CFG_ADDR_RX1: return 1;
                        `CFG_ADDR_TX:  return 2;
                        `CFG_ADDR_FC:  return 3;
                        `CFG_ADDR_RS:  return 4;
                        default:       return -1;
                endcase
        endfunction

        task automatic add_entry(input mgmt_op_e op, input logic [9:0] addr,
                                 input logic [31:0] wd, input logic [63:0] exp,
                                 input int midx, input int nw, input bit shadow);
                entry_t e;
                e = '{op, addr, wd, exp, midx, nw, shadow};
                entries.push_back(e);
        endtask

        task automatic build_table();
                add_entry(OP_READ,  10'h200, '0, `CFG_RST_RX0, -1, 1, 0);      // reset values
                add_entry(OP_READ,  10'h240, '0, `CFG_RST_RX1, -1, 1, 0);
                add_entry(OP_READ,  10'h280, '0, `CFG_RST_TX,  -1, 1, 0);
                add_entry(OP_READ,  10'h2C0, '0, `CFG_RST_FC,  -1, 1, 0);
                add_entry(OP_READ,  10'h300, '0, `CFG_RST_RS,  -1, 1, 0);
                add_entry(OP_WRITE, 10'h200, 32'ha5a5_1234, '0, -1, 0, 0);
                add_entry(OP_WRITE, 10'h240, 32'hf800_beef, '0, -1, 0, 0);
                add_entry(OP_WRITE, 10'h280, 32'hff00_0000, '0, -1, 0, 0);
                add_entry(OP_WRITE, 10'h2C0, 32'h2000_0000, '0, -1, 0, 0);
                add_entry(OP_WRITE, 10'h300, 32'h0800_0000, '0, -1, 0, 0);
                add_entry(OP_READ,  10'h200, '0, 32'ha5a5_1234, -1, 1, 0);
                add_entry(OP_READ,  10'h240, '0, 32'hf800_beef, -1, 1, 0);
                add_entry(OP_READ,  10'h280, '0, 32'hff00_0000, -1, 1, 0);
                add_entry(OP_READ,  10'h2C0, '0, 32'h2000_0000, -1, 1, 0);
                add_entry(OP_READ,  10'h300, '0, 32'h0800_0000, -1, 1, 0);
                add_entry(OP_READ,  10'h204, '0, '0, -1, 1, 0);                // unmapped
                add_entry(OP_WRITE, 10'h005, 32'h0000_1234, '0, -1, 0, 0);     // stat space
                add_entry(OP_READ,  10'h000, '0, '0, 0, 2, 0);
                add_entry(OP_READ,  10'h005, '0, '0, 5, 2, 0);
                add_entry(OP_READ,  10'h012, '0, '0, 18, 2, 0);
                add_entry(OP_READ,  10'h007, '0, '0, 7, 2, 1);                 // busy window
                add_entry(OP_READ,  10'h013, '0, '0, -1, 2, 0);                // no counter
                add_entry(OP_READ,  10'h01F, '0, '0, -1, 2, 0);
                add_entry(OP_READ,  10'h200, '0, 32'ha5a5_1234, -1, 1, 0);
        endtask

        task automatic issue(input mgmt_op_e op, input logic [9:0] addr, input logic [31:0] wd);
                @(posedge rxclk);
                mgmt_req     <= 1'b1;
                mgmt_opcode  <= op;
                mgmt_addr    <= addr;
                mgmt_wr_data <= wd;
        endtask

        task automatic stat_burst();
                logic [31:0] len;
                logic [31:0] pat;
                rand_bits(4, len);
                repeat (len + 1) begin
                        rand_bits(`NUM_RX_STAT, pat);
                        @(posedge rxclk);
                        rx_stat_inc <= pat[`NUM_RX_STAT-1:0];
                        for (int i = 0; i < `NUM_RX_STAT; i++)
                                if (pat[i])
                                        model_cnt[i] = model_cnt[i] + 64'd1;
                end
                @(posedge rxclk);
                rx_stat_inc <= '0;
                @(posedge rxclk);               // second quiet cycle before the read
        endtask

        task automatic check_vectors();
                logic [`CFG_RX_W-1:0] rx_exp;
                logic [`CFG_TX_W-1:0] tx_exp;
                rx_exp = {cfg_model[1][31:27], cfg_model[1][15:0], cfg_model[0]};
                tx_exp = {cfg_model[4][27], cfg_model[2][31:24], cfg_model[3][30]};
                if (cfg_rx !== rx_exp) begin
                        $display("[FAIL] %0t cfg_rx_o exp=%h got=%h", $time, rx_exp, cfg_rx);
                        errors++;
                end
                if (cfg_tx !== tx_exp) begin
                        $display("[FAIL] %0t cfg_tx_o exp=%h got=%h", $time, tx_exp, cfg_tx);
                        errors++;
                end
        endtask

        ////////////////////
        // one table entry

        task automatic run_entry(input int n, input entry_t e);
                logic [63:0] exp;
                int          err0;
                bit          seen;
                err0 = errors;
                if (e.nw == 2)
                        stat_burst();
                exp = (e.midx >= 0) ? model_cnt[e.midx] : e.exp;
                issue(e.op, e.addr, e.wdata);
                @(posedge rxclk);
                if (e.shadow) begin
                        mgmt_req     <= 1'b1;           // rdy is low so this is dropped
                        mgmt_opcode  <= OP_WRITE;
                        mgmt_addr    <= 10'h200;
                        mgmt_wr_data <= 32'hdead_beef;
                        @(posedge rxclk);
                end
                mgmt_req <= 1'b0;
                if (e.nw == 0) begin
                        if (e.addr[`CFG_SPACE_BIT] && cfg_index(e.addr) >= 0)
                                cfg_model[cfg_index(e.addr)] = e.wdata;
                        repeat (2) @(negedge rxclk);    // write lands at E1
                end else begin
                        seen = 1'b0;
                        for (int k = 0; k < 4 && !seen; k++) begin
                                @(negedge rxclk);
                                seen = mgmt_rd_valid;
                        end
                        if (!seen) begin
                                $display("entry %0d: no read valid within four cycles", n);
                                errors++;
                        end else begin
                                if (mgmt_rd_data !== exp[31:0]) begin
                                        $display("[FAIL] %0t mgmt_rd_data_o exp=%h got=%h",
                                                 $time, exp[31:0], mgmt_rd_data);
                                        errors++;
                                end
                                if (e.nw == 2) begin
                                        if (mgmt_rdy !== 1'b0) begin    // still busy after E2
                                                $display("[FAIL] %0t mgmt_rdy_o exp=0 got=%b",
                                                         $time, mgmt_rdy);
                                                errors++;
                                        end
                                        @(negedge rxclk);       // high word next cycle
                                        if (!mgmt_rd_valid) begin
                                                $display("entry %0d: high word never came", n);
                                                errors++;
                                        end else if (mgmt_rd_data !== exp[63:32]) begin
                                                $display("[FAIL] %0t mgmt_rd_data_o exp=%h got=%h",
                                                         $time, exp[63:32], mgmt_rd_data);
                                                errors++;
                                        end
                                        if (mgmt_rdy !== 1'b1) begin    // ready again after E3
                                                $display("[FAIL] %0t mgmt_rdy_o exp=1 got=%b",
                                                         $time, mgmt_rdy);
                                                errors++;
                                        end
                                end
                        end
                end
                check_vectors();
                tests++;
                if (errors != err0)
                        failed++;
                $display("entry %0d %s addr %h: %s", n, (e.op == OP_WRITE) ? "write" : "read",
                         e.addr, (errors == err0) ? "ok" : "failed");
        endtask

        task automatic back_to_back_reads();
                int err0;
                err0 = errors;
                issue(OP_READ, 10'h240, '0);
                issue(OP_READ, 10'h280, '0);
                @(posedge rxclk);
                mgmt_req <= 1'b0;
                @(negedge rxclk);
                if (mgmt_rd_valid !== 1'b0) begin
                        $display("[FAIL] %0t mgmt_rd_valid_o exp=0 got=%b",
                                 $time, mgmt_rd_valid);
                        errors++;
                end
                for (int k = 1; k <= 2; k++) begin
                        @(negedge rxclk);               // two edges after each E0
                        if (mgmt_rd_valid !== 1'b1) begin
                                $display("[FAIL] %0t mgmt_rd_valid_o exp=1 got=%b",
                                         $time, mgmt_rd_valid);
                                errors++;
                        end else if (mgmt_rd_data !== cfg_model[k]) begin
                                $display("[FAIL] %0t mgmt_rd_data_o exp=%h got=%h",
                                         $time, cfg_model[k], mgmt_rd_data);
                                errors++;
                        end
                end
                tests++;
                if (errors != err0)
                        failed++;
                $display("back to back reads: %s", (errors == err0) ? "ok" : "failed");
        endtask

        ////////////////////
        // main sequence

        initial begin
                reset        = 1'b1;
                mgmt_req     = 1'b0;
                mgmt_opcode  = OP_READ;
                mgmt_addr    = '0;
                mgmt_wr_data = '0;
                rx_stat_inc  = '0;
                lfsr         = 32'd84624;
                cfg_model    = '{`CFG_RST_RX0, `CFG_RST_RX1, `CFG_RST_TX, `CFG_RST_FC, `CFG_RST_RS};
                foreach (model_cnt[i])
                        model_cnt[i] = '0;
                build_table();
                cycle_limit = (entries.size() + 2) * (MAX_BURST + 8) + RESET_CYC;
                repeat (RESET_CYC) @(posedge rxclk);
                reset <= 1'b0;
                @(negedge rxclk);
                if (mgmt_rdy !== 1'b1) begin
                        $display("[FAIL] %0t mgmt_rdy_o exp=1 got=%b", $time, mgmt_rdy);
                        errors++;
                end
                if (mgmt_rd_valid !== 1'b0) begin
                        $display("[FAIL] %0t mgmt_rd_valid_o exp=0 got=%b", $time, mgmt_rd_valid);
                        errors++;
                end
                foreach (entries[i])
                        run_entry(i, entries[i]);
                back_to_back_reads();
                errors = errors + mgmt_top_i.u_assert.fail_cnt;
                $display("tests %0d, failed %0d, errors %0d", tests, failed, errors);
                if (errors == 0)
                        $display("** PASS **");
                else
                        $display("** FAIL **");
                $finish;
        end

        // watchdog with a limit from the table length
        initial begin
                while (cycle_limit == 0 || cycles <= cycle_limit) begin
                        @(posedge rxclk);
                        cycles++;
                end
                $display("timeout after %0d cycles, the run did not finish", cycles);
                $display("** FAIL **");
                $finish;
        end

endmodule

//--- tb_mgmt_assert.sv
`timescale 1ns/10ps
`include "mgmt_consts.svh"

module mgmt_assert import mgmt_pkg::*; (
        input  logic                            rxclk,
        input  logic                            reset,
        input  logic                            req_i,
        input  mgmt_op_e                        opcode_i,
        input  logic [`MGMT_ADDR_W-1:0]         addr_i,
        input  logic                            rdy_i,
        input  logic                            rd_valid_i
);

        int     fail_cnt = 0;           // read by the testbench at the end
        logic   rd_acc;                 // read accepted at this edge
        logic   stat_acc;               // statistics read accepted

        assign rd_acc   = req_i & rdy_i & (opcode_i == OP_READ);
        assign stat_acc = rd_acc & ~addr_i[`CFG_SPACE_BIT];

        ////////////////////
        // port properties

        no_valid_in_reset: assert property (@(posedge rxclk) reset |-> !rd_valid_i)
                else begin
                        $error("read valid while reset is high");
                        fail_cnt++;
                end

        busy_after_stat: assert property (@(posedge rxclk) disable iff (reset)
                stat_acc |=> !rdy_i)
                else begin
                        $error("ready still high after a statistics read");
                        fail_cnt++;
                end

        // two words in a row come from a stat read or two reads taken back to back
        double_valid: assert property (@(posedge rxclk) disable iff (reset)
                (rd_valid_i && $past(rd_valid_i)) |->
                ($past(stat_acc, 4) || ($past(rd_acc, 3) && $past(rd_acc, 4))))
                else begin
                        $error("read valid two cycles in a row without a cause");
                        fail_cnt++;
                end

endmodule
